// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

    // basic data and address word
    typedef logic [31:0] word_t;

    // architectural register number, r0 to r31
    typedef logic [4:0] reg_addr_t;

    // operations seen by the commit stage
    // NOP sits at zero so a cleared record decodes as a bubble
    typedef enum logic [4:0] {
        NOP  = 5'd0,
        ADDU = 5'd1,
        SUBU = 5'd2,
        AND  = 5'd3,
        OR   = 5'd4,
        XOR  = 5'd5,
        SLT  = 5'd6,
        SLL  = 5'd7,
        LUI  = 5'd8,
        LB   = 5'd9,
        LBU  = 5'd10,
        LH   = 5'd11,
        LHU  = 5'd12,
        LW   = 5'd13,
        SW   = 5'd14,
        BEQ  = 5'd15,
        BNE  = 5'd16,
        JR   = 5'd17,
        ERET = 5'd18
    } decoded_op_t;

    // decoded control bits of one instruction
    typedef struct packed {
        // writes destreg
        logic regwrite;
        // result comes from data memory
        logic memtoreg;
        // store
        logic memwrite;
        // conditional branch, predictor tracked
        logic branch;
        // jump register
        logic jr;
        // alu result finished in commit, not in execute
        logic delayed;
        // return from exception
        logic eret;
    } ctl_t;

endpackage

// ==== commit_pkg.sv ====
package commit_pkg;

    // prediction made at fetch, carried down the pipe
    typedef struct packed {
        logic                taken;
        mips_isa_pkg::word_t target;
    } pred_t;

    // one slot as handed over by execute
    typedef struct packed {
        mips_isa_pkg::decoded_op_t op;
        mips_isa_pkg::ctl_t        ctl;
        mips_isa_pkg::reg_addr_t   destreg;
        mips_isa_pkg::word_t       pcplus4;
        // operand values already read by execute
        mips_isa_pkg::word_t       srca;
        mips_isa_pkg::word_t       srcb;
        // only meaningful when ctl.delayed is clear
        mips_isa_pkg::word_t       result;
        // resolved branch direction
        logic                      taken;
        mips_isa_pkg::word_t       pcbranch;
        pred_t                     pred;
        logic                      valid;
    } exec_data_t;

    // redirect request towards fetch
    typedef struct packed {
        logic                exception_valid;
        mips_isa_pkg::word_t pcexception;
        logic                is_eret;
        mips_isa_pkg::word_t epc;
        logic                branch_miss;
        mips_isa_pkg::word_t pcbranch;
        logic                jr_miss;
        mips_isa_pkg::word_t pcjr;
    } redirect_t;

    // branch predictor training write
    typedef struct packed {
        logic                wen;
        // address of the branch itself
        mips_isa_pkg::word_t pc;
        logic                taken;
        mips_isa_pkg::word_t target;
    } predictor_upd_t;

    // one forwarding entry
    typedef struct packed {
        logic                    wen;
        mips_isa_pkg::reg_addr_t destreg;
        mips_isa_pkg::word_t     result;
        logic                    ready;
    } bypass_entry_t;

    // forwarding record, index matches the slot number
    typedef struct packed {
        bypass_entry_t [1:0] entry;
    } bypass_t;

endpackage

// ==== mem_response_hold.sv ====
module mem_response_hold (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                dmem_en,
    input  mips_isa_pkg::word_t dmem_rdata,
    input  logic                dmem_data_ok,
    output mips_isa_pkg::word_t rdata,
    output logic                finish
);

    // completion seen earlier in the current stall
    logic                held_ok;
    // read data captured with that completion
    mips_isa_pkg::word_t held_rdata;

    // the hold only lives for the length of one stall
    always_ff @(posedge clk)
    begin
        if (!rst_n || !stall)
        begin
            held_ok    <= 1'b0;
            held_rdata <= '0;
        end
        else
        begin
            held_ok <= held_ok | dmem_data_ok;
            if (dmem_data_ok)
            begin
                held_rdata <= dmem_rdata;
            end
        end
    end

    // live response wins over the held copy
    always_comb
    begin
        if (dmem_data_ok)
        begin
            rdata = dmem_rdata;
        end
        else
        begin
            rdata = held_rdata;
        end
    end

    // no access means nothing to wait for
    assign finish = !dmem_en || dmem_data_ok || held_ok;

endmodule

// ==== load_format.sv ====
module load_format (
    input  mips_isa_pkg::word_t       raw,
    input  logic [1:0]                addr_lo,
    input  mips_isa_pkg::decoded_op_t op,
    output mips_isa_pkg::word_t       value
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // little endian, byte 0 in bits 7:0
    assign byte_sel = raw[{addr_lo, 3'b000} +: 8];

    // halfword picked by address bit 1 only
    assign half_sel = addr_lo[1] ? raw[31:16] : raw[15:0];

    always_comb
    begin
        case (op)
            mips_isa_pkg::LB:
            begin
                value = {{24{byte_sel[7]}}, byte_sel};
            end
            mips_isa_pkg::LBU:
            begin
                value = {24'b0, byte_sel};
            end
            mips_isa_pkg::LH:
            begin
                value = {{16{half_sel[15]}}, half_sel};
            end
            mips_isa_pkg::LHU:
            begin
                value = {16'b0, half_sel};
            end
            mips_isa_pkg::LW:
            begin
                value = raw;
            end
            // not a load
            default:
            begin
                value = '0;
            end
        endcase
    end

endmodule

// ==== late_execute.sv ====
module late_execute (
    input  commit_pkg::exec_data_t [1:0] in,
    input  mips_isa_pkg::word_t          load_value,
    output commit_pkg::exec_data_t [1:0] out
);

    // alu ops that execute may leave for commit
    // anything else keeps the result execute already produced
    function automatic mips_isa_pkg::word_t alu_result(
        input mips_isa_pkg::decoded_op_t op,
        input mips_isa_pkg::word_t       a,
        input mips_isa_pkg::word_t       b,
        input mips_isa_pkg::word_t       fallback
    );
        case (op)
            mips_isa_pkg::ADDU:
            begin
                alu_result = a + b;
            end
            mips_isa_pkg::SUBU:
            begin
                alu_result = a - b;
            end
            mips_isa_pkg::AND:
            begin
                alu_result = a & b;
            end
            mips_isa_pkg::OR:
            begin
                alu_result = a | b;
            end
            mips_isa_pkg::XOR:
            begin
                alu_result = a ^ b;
            end
            // signed compare
            mips_isa_pkg::SLT:
            begin
                alu_result = {31'b0, $signed(a) < $signed(b)};
            end
            // shift amount is the low five bits of srcb
            mips_isa_pkg::SLL:
            begin
                alu_result = a << b[4:0];
            end
            mips_isa_pkg::LUI:
            begin
                alu_result = {b[15:0], 16'b0};
            end
            default:
            begin
                alu_result = fallback;
            end
        endcase
    endfunction

    // only one memory port, so one load value serves whichever slot loads
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            out[i] = in[i];
            if (in[i].ctl.memtoreg)
            begin
                out[i].result = load_value;
            end
            else if (in[i].ctl.delayed)
            begin
                out[i].result = alu_result(in[i].op, in[i].srca, in[i].srcb, in[i].result);
            end
        end
    end

endmodule

// ==== redirect_unit.sv ====
module redirect_unit (
    input  commit_pkg::exec_data_t [1:0] in,
    input  commit_pkg::exec_data_t [1:0] out,
    input  logic                         exception_valid,
    input  mips_isa_pkg::word_t          exception_pc,
    input  mips_isa_pkg::word_t          cp0_epc,
    output commit_pkg::redirect_t        redirect,
    output commit_pkg::predictor_upd_t   predictor_upd,
    output commit_pkg::bypass_t          bypass
);

    logic branch_valid;
    logic jr_valid;

    // control transfers only ever sit in slot 1
    assign branch_valid = in[1].valid && in[1].ctl.branch;
    assign jr_valid     = in[1].valid && in[1].ctl.jr;

    // exception comes straight from the exception unit
    assign redirect.exception_valid = exception_valid;
    assign redirect.pcexception     = exception_pc;

    assign redirect.is_eret = (in[1].valid && in[1].ctl.eret) ||
                              (in[0].valid && in[0].ctl.eret);
    assign redirect.epc     = cp0_epc;

    // direction mispredict
    assign redirect.branch_miss = branch_valid && (in[1].taken != in[1].pred.taken);

    // predicted taken but fell through, so restart after the delay slot
    assign redirect.pcbranch = in[1].pred.taken ? in[0].pcplus4 : in[1].pcbranch;

    // jr target is only right if predicted taken to the same address
    assign redirect.jr_miss = jr_valid &&
                              (!in[1].pred.taken || (in[1].pred.target != in[1].srca));
    assign redirect.pcjr    = in[1].srca;

    // train on every committed branch, hit or miss
    assign predictor_upd.wen    = branch_valid;
    assign predictor_upd.pc     = in[1].pcplus4 - 32'd4;
    assign predictor_upd.taken  = in[1].taken;
    assign predictor_upd.target = in[1].pcbranch;

    // forwarding uses the final results, after load and late alu
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            bypass.entry[i].wen     = out[i].valid && out[i].ctl.regwrite;
            bypass.entry[i].destreg = out[i].destreg;
            bypass.entry[i].result  = out[i].result;
            bypass.entry[i].ready   = out[i].valid;
        end
    end

endmodule

// ==== commit_stage.sv ====
module commit_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  commit_pkg::exec_data_t [1:0] in,
    input  logic                         stall,
    input  logic                         dmem_en,
    input  mips_isa_pkg::word_t          dmem_addr,
    input  mips_isa_pkg::word_t          dmem_rdata,
    input  logic                         dmem_data_ok,
    input  logic                         exception_valid,
    input  mips_isa_pkg::word_t          exception_pc,
    input  mips_isa_pkg::word_t          cp0_epc,
    output commit_pkg::exec_data_t [1:0] out,
    output logic                         finish,
    output commit_pkg::redirect_t        redirect,
    output commit_pkg::predictor_upd_t   predictor_upd,
    output commit_pkg::bypass_t          bypass
);

    mips_isa_pkg::word_t       rdata;
    mips_isa_pkg::word_t       load_value;
    logic                      mem_in_slot1;
    mips_isa_pkg::decoded_op_t mem_op;

    // slot 1 owns the port if it touches memory at all
    assign mem_in_slot1 = in[1].ctl.memwrite || in[1].ctl.memtoreg;
    assign mem_op       = mem_in_slot1 ? in[1].op : in[0].op;

    mem_response_hold u_mem_response_hold (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .dmem_en      (dmem_en),
        .dmem_rdata   (dmem_rdata),
        .dmem_data_ok (dmem_data_ok),
        .rdata        (rdata),
        .finish       (finish)
    );

    load_format u_load_format (
        .raw     (rdata),
        .addr_lo (dmem_addr[1:0]),
        .op      (mem_op),
        .value   (load_value)
    );

    late_execute u_late_execute (
        .in         (in),
        .load_value (load_value),
        .out        (out)
    );

    redirect_unit u_redirect_unit (
        .in              (in),
        .out             (out),
        .exception_valid (exception_valid),
        .exception_pc    (exception_pc),
        .cp0_epc         (cp0_epc),
        .redirect        (redirect),
        .predictor_upd   (predictor_upd),
        .bypass          (bypass)
    );

endmodule

// ==== commit_assertions.sv ====
module commit_assertions (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         stall,
    input logic                         dmem_en,
    input logic                         finish,
    input logic                         held_ok,
    input mips_isa_pkg::word_t          held_rdata,
    input commit_pkg::exec_data_t [1:0] in,
    input commit_pkg::redirect_t        redirect
);

    // number of failed assertions
    int error_count = 0;

    // no access means nothing to wait for
    property finish_without_access;
        @(posedge clk) disable iff (!rst_n)
        !dmem_en |-> finish;
    endproperty

    // hold lasts one stall only
    property hold_clear_after_release;
        @(posedge clk) disable iff (!rst_n)
        !stall |=> (!held_ok && (held_rdata == '0));
    endproperty

    property branch_miss_source;
        @(posedge clk) disable iff (!rst_n)
        redirect.branch_miss |-> (in[1].valid && in[1].ctl.branch);
    endproperty

    assert property (finish_without_access)
    else
    begin
        error_count++;
        $error("finish low while no memory access is enabled");
    end

    assert property (hold_clear_after_release)
    else
    begin
        error_count++;
        $error("held registers not cleared after stall was low");
    end

    assert property (branch_miss_source)
    else
    begin
        error_count++;
        $error("branch_miss raised without a valid branch in slot 1");
    end

endmodule

bind commit_stage commit_assertions u_commit_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .dmem_en    (dmem_en),
    .finish     (finish),
    .held_ok    (u_mem_response_hold.held_ok),
    .held_rdata (u_mem_response_hold.held_rdata),
    .in         (in),
    .redirect   (redirect)
);

// ==== tb_commit_stage.sv ====
module tb_commit_stage;

    localparam int num_trans   = 2000;
    localparam int max_cycles  = num_trans * 8;
    localparam int drive_delay = 10;
    localparam int check_delay = 20;

    logic                         clk;
    logic                         rst_n;
    commit_pkg::exec_data_t [1:0] in;
    logic                         stall;
    logic                         dmem_en;
    mips_isa_pkg::word_t          dmem_addr;
    mips_isa_pkg::word_t          dmem_rdata;
    logic                         dmem_data_ok;
    logic                         exception_valid;
    mips_isa_pkg::word_t          exception_pc;
    mips_isa_pkg::word_t          cp0_epc;
    commit_pkg::exec_data_t [1:0] out;
    logic                         finish;
    commit_pkg::redirect_t        redirect;
    commit_pkg::predictor_upd_t   predictor_upd;
    commit_pkg::bypass_t          bypass;

    logic [31:0]         rng_state;
    logic                model_held_ok;
    mips_isa_pkg::word_t model_held_word;
    int                  cycle_count;

    commit_stage dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .in              (in),
        .stall           (stall),
        .dmem_en         (dmem_en),
        .dmem_addr       (dmem_addr),
        .dmem_rdata      (dmem_rdata),
        .dmem_data_ok    (dmem_data_ok),
        .exception_valid (exception_valid),
        .exception_pc    (exception_pc),
        .cp0_epc         (cp0_epc),
        .out             (out),
        .finish          (finish),
        .redirect        (redirect),
        .predictor_upd   (predictor_upd),
        .bypass          (bypass)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic is_mem_op(input mips_isa_pkg::decoded_op_t op);
        return op inside {mips_isa_pkg::LB, mips_isa_pkg::LBU, mips_isa_pkg::LH,
                          mips_isa_pkg::LHU, mips_isa_pkg::LW, mips_isa_pkg::SW};
    endfunction

    // decode table used to build consistent stimulus
    function automatic mips_isa_pkg::ctl_t ctl_for(input mips_isa_pkg::decoded_op_t op,
                                                   input logic late);
        mips_isa_pkg::ctl_t c;
        logic               is_alu;
        logic               is_load;
        is_alu     = op inside {mips_isa_pkg::ADDU, mips_isa_pkg::SUBU, mips_isa_pkg::AND,
                                mips_isa_pkg::OR, mips_isa_pkg::XOR, mips_isa_pkg::SLT,
                                mips_isa_pkg::SLL, mips_isa_pkg::LUI};
        is_load    = is_mem_op(op) && (op != mips_isa_pkg::SW);
        c          = '0;
        c.regwrite = is_alu || is_load;
        c.memtoreg = is_load;
        c.memwrite = (op == mips_isa_pkg::SW);
        c.branch   = (op == mips_isa_pkg::BEQ) || (op == mips_isa_pkg::BNE);
        c.jr       = (op == mips_isa_pkg::JR);
        c.delayed  = is_alu && late;
        c.eret     = (op == mips_isa_pkg::ERET);
        return c;
    endfunction

    // reference alu for delayed ops
    function automatic mips_isa_pkg::word_t model_alu(input mips_isa_pkg::decoded_op_t op,
                                                      input mips_isa_pkg::word_t a,
                                                      input mips_isa_pkg::word_t b,
                                                      input mips_isa_pkg::word_t keep);
        case (op)
            mips_isa_pkg::ADDU: return a + b;
            mips_isa_pkg::SUBU: return a + ~b + 32'd1;
            mips_isa_pkg::AND:  return a & b;
            mips_isa_pkg::OR:   return a | b;
            mips_isa_pkg::XOR:  return a ^ b;
            // differing signs decide by sign of a
            mips_isa_pkg::SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            mips_isa_pkg::SLL:  return a << b[4:0];
            mips_isa_pkg::LUI:  return b << 16;
            default:            return keep;
        endcase
    endfunction

    function automatic mips_isa_pkg::word_t model_load(input mips_isa_pkg::word_t raw,
                                                       input logic [1:0] lo,
                                                       input mips_isa_pkg::decoded_op_t op);
        mips_isa_pkg::word_t b_sh;
        mips_isa_pkg::word_t h_sh;
        b_sh = raw >> (8 * lo);
        h_sh = raw >> (16 * lo[1]);
        case (op)
            mips_isa_pkg::LB:  return {{24{b_sh[7]}}, b_sh[7:0]};
            mips_isa_pkg::LBU: return {24'h0, b_sh[7:0]};
            mips_isa_pkg::LH:  return {{16{h_sh[15]}}, h_sh[15:0]};
            mips_isa_pkg::LHU: return {16'h0, h_sh[15:0]};
            mips_isa_pkg::LW:  return raw;
            default:           return '0;
        endcase
    endfunction

    task automatic stop_on_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
        assert (got === exp)
        else
        begin
            $display("MISMATCH %s dut=%0h expected=%0h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_outputs();
        commit_pkg::exec_data_t [1:0] exp_out;
        commit_pkg::redirect_t        exp_redirect;
        commit_pkg::predictor_upd_t   exp_upd;
        commit_pkg::bypass_t          exp_bypass;
        mips_isa_pkg::word_t          eff_word;
        mips_isa_pkg::decoded_op_t    mem_op;
        logic                         exp_finish;
        eff_word   = dmem_data_ok ? dmem_rdata : model_held_word;
        mem_op     = is_mem_op(in[1].op) ? in[1].op : in[0].op;
        exp_finish = !dmem_en || dmem_data_ok || model_held_ok;
        for (int i = 0; i < 2; i++)
        begin
            exp_out[i] = in[i];
            if (in[i].ctl.memtoreg)
            begin
                exp_out[i].result = model_load(eff_word, dmem_addr[1:0], mem_op);
            end
            else if (in[i].ctl.delayed)
            begin
                exp_out[i].result = model_alu(in[i].op, in[i].srca, in[i].srcb, in[i].result);
            end
            exp_bypass.entry[i].wen     = in[i].valid && in[i].ctl.regwrite;
            exp_bypass.entry[i].destreg = in[i].destreg;
            exp_bypass.entry[i].result  = exp_out[i].result;
            exp_bypass.entry[i].ready   = in[i].valid;
        end
        exp_redirect.exception_valid = exception_valid;
        exp_redirect.pcexception     = exception_pc;
        exp_redirect.is_eret         = (in[0].valid && in[0].op == mips_isa_pkg::ERET) ||
                                       (in[1].valid && in[1].op == mips_isa_pkg::ERET);
        exp_redirect.epc             = cp0_epc;
        exp_redirect.branch_miss     = in[1].valid && in[1].ctl.branch &&
                                       (in[1].taken != in[1].pred.taken);
        exp_redirect.pcbranch        = in[1].pred.taken ? in[0].pcplus4 : in[1].pcbranch;
        exp_redirect.jr_miss         = in[1].valid && in[1].ctl.jr &&
                                       (!in[1].pred.taken || in[1].pred.target != in[1].srca);
        exp_redirect.pcjr            = in[1].srca;
        exp_upd.wen    = in[1].valid && in[1].ctl.branch;
        exp_upd.pc     = in[1].pcplus4 - 32'd4;
        exp_upd.taken  = in[1].taken;
        exp_upd.target = in[1].pcbranch;
        compare_value("finish", finish, exp_finish);
        compare_value("out[0]", out[0], exp_out[0]);
        compare_value("out[1]", out[1], exp_out[1]);
        compare_value("redirect", redirect, exp_redirect);
        compare_value("predictor_upd", predictor_upd, exp_upd);
        compare_value("bypass", bypass, exp_bypass);
    endtask

    task automatic settle_and_check();
        #(check_delay);
        check_outputs();
    endtask

    // model of the hold registers, updated from inputs still applied at the edge
    task automatic advance_cycle();
        @(posedge clk);
        if (!rst_n || !stall)
        begin
            model_held_ok   = 1'b0;
            model_held_word = '0;
        end
        else
        begin
            model_held_ok = model_held_ok | dmem_data_ok;
            if (dmem_data_ok)
            begin
                model_held_word = dmem_rdata;
            end
        end
        #(drive_delay);
    endtask

    task automatic make_slot(input logic older, output commit_pkg::exec_data_t rec);
        int                        r;
        mips_isa_pkg::decoded_op_t op;
        // only slot 1 may carry branches and jr
        if (older)
        begin
            op = mips_isa_pkg::decoded_op_t'(5'(next_rand() % 19));
        end
        else
        begin
            r  = next_rand() % 16;
            op = (r == 15) ? mips_isa_pkg::ERET : mips_isa_pkg::decoded_op_t'(5'(r));
        end
        rec.op           = op;
        rec.ctl          = ctl_for(op, 1'(next_rand() % 2));
        rec.destreg      = 5'(next_rand());
        rec.pcplus4      = next_rand() & 32'hffff_fffc;
        rec.srca         = next_rand();
        rec.srcb         = next_rand();
        rec.result       = next_rand();
        rec.taken        = 1'(next_rand() % 2);
        rec.pcbranch     = next_rand() & 32'hffff_fffc;
        rec.pred.taken   = 1'(next_rand() % 2);
        rec.pred.target  = (next_rand() % 2) ? rec.srca : next_rand();
        rec.valid        = (next_rand() % 8) != 0;
    endtask

    task automatic run_transaction();
        commit_pkg::exec_data_t s0;
        commit_pkg::exec_data_t s1;
        int                     wait_cycles;
        int                     k;
        logic                   seen;
        make_slot(1'b0, s0);
        make_slot(1'b1, s1);
        // single memory port, one memory op per pair
        if (is_mem_op(s1.op) && is_mem_op(s0.op))
        begin
            s0.op  = mips_isa_pkg::ADDU;
            s0.ctl = ctl_for(mips_isa_pkg::ADDU, 1'(next_rand() % 2));
        end
        in[0]           = s0;
        in[1]           = s1;
        exception_valid = (next_rand() % 8) == 0;
        exception_pc    = next_rand();
        cp0_epc         = next_rand();
        dmem_addr       = next_rand();
        dmem_rdata      = next_rand();
        dmem_data_ok    = 1'b0;
        dmem_en         = is_mem_op(s1.op) ? s1.valid : (is_mem_op(s0.op) && s0.valid);
        stall           = dmem_en;
        if (!dmem_en)
        begin
            settle_and_check();
            advance_cycle();
        end
        else
        begin
            wait_cycles = next_rand() % 5;
            k           = 0;
            seen        = 1'b0;
            while (!seen)
            begin
                dmem_data_ok = (k == wait_cycles);
                dmem_rdata   = next_rand();
                settle_and_check();
                seen = finish;
                advance_cycle();
                k++;
            end
            // pulse is over, the held word must still come through
            dmem_data_ok = 1'b0;
            dmem_rdata   = next_rand();
            stall        = 1'b0;
            settle_and_check();
            advance_cycle();
        end
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count <= max_cycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not end within %0d cycles", max_cycles);
        stop_on_failure();
    end

    initial
    begin
        rng_state       = 32'hea10_4318;
        model_held_ok   = 1'b0;
        model_held_word = '0;
        rst_n           = 1'b0;
        in              = '0;
        stall           = 1'b0;
        dmem_en         = 1'b0;
        dmem_addr       = '0;
        dmem_rdata      = '0;
        dmem_data_ok    = 1'b0;
        exception_valid = 1'b0;
        exception_pc    = '0;
        cp0_epc         = '0;
        repeat (16) advance_cycle();
        // idle outputs while still in reset
        settle_and_check();
        rst_n = 1'b1;
        repeat (num_trans) run_transaction();
        if (dut.u_commit_assertions.error_count == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== commit_stage.f ====
mips_isa_pkg.sv
commit_pkg.sv
mem_response_hold.sv
load_format.sv
late_execute.sv
redirect_unit.sv
commit_stage.sv
commit_assertions.sv
tb_commit_stage.sv
